//--- hdl/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
    input  srcIsaPkg::aluOpT aluOp,
    input  logic [srcIsaPkg::wordWidth-1:0] a,     // from Y
    input  logic [srcIsaPkg::wordWidth-1:0] b,     // from bus
    output logic [srcIsaPkg::wordWidth-1:0] result
);

    always_comb begin
        case (aluOp)
            srcIsaPkg::aluAdd: begin
                result = a + b;
            end
            srcIsaPkg::aluSub: begin
                result = a - b;
            end
            srcIsaPkg::aluAnd: begin
                result = a & b;
            end
            srcIsaPkg::aluOr: begin
                result = a | b;
            end
            srcIsaPkg::aluIncB: begin
                result = b + 1'b1;
            end
            default: begin
                result = b;                 // pass, also nop
            end
        endcase
    end

endmodule

//--- hdl/controlBus.sv
`timescale 1ns/10ps

interface controlBus;

    logic pcOut, zLowOut, mdrOut, regOut, cOut, inPortOut;          // bus drivers
    logic pcIn, irIn, yIn, zIn, marIn, mdrIn, regIn, outPortIn;     // register loads
    logic gra, grb, grc, baOut;                                     // register select
    logic incPc;
    logic memRead;
    logic memWrite;
    logic mdrRead;                      // MDR takes memory data, not bus
    srcIsaPkg::aluOpT aluOp;
    logic [srcIsaPkg::wordWidth-1:0] ir;

    modport sequencer (
        output pcOut, zLowOut, mdrOut, regOut, cOut, inPortOut,
        output pcIn, irIn, yIn, zIn, marIn, mdrIn, regIn, outPortIn,
        output gra, grb, grc, baOut,
        output incPc, memRead, memWrite, mdrRead, aluOp,
        input  ir
    );

    modport datapath (
        input  pcOut, zLowOut, mdrOut, regOut, cOut, inPortOut,
        input  pcIn, irIn, yIn, zIn, marIn, mdrIn, regIn, outPortIn,
        input  gra, grb, grc, baOut,
        input  incPc, memRead, memWrite, mdrRead, aluOp,
        output ir
    );

endinterface

//--- hdl/controlSequencer.sv
`timescale 1ns/10ps

module controlSequencer (
    input  logic clock,
    input  logic reset,
    input  logic run,
    input  logic timerDone,
    output logic timerStart,
    output logic halted,
    controlBus.sequencer ctl
);

    srcCtrlPkg::stepT state;
    srcCtrlPkg::stepT nextState;
    srcIsaPkg::opcodeT opcode;
    srcIsaPkg::aluOpT execAluOp;
    logic isMem;
    logic isRegOp;

    assign opcode = srcIsaPkg::opcodeT'(ctl.ir[srcIsaPkg::opMsb -: srcIsaPkg::opcodeWidth]);
    assign isMem = (opcode == srcIsaPkg::opLd) || (opcode == srcIsaPkg::opSt);
    assign isRegOp = opcode inside {srcIsaPkg::opAdd, srcIsaPkg::opSub,
                                    srcIsaPkg::opAnd, srcIsaPkg::opOr};
    assign execAluOp = (opcode == srcIsaPkg::opSub) ? srcIsaPkg::aluSub :
                       (opcode == srcIsaPkg::opAnd) ? srcIsaPkg::aluAnd :
                       (opcode == srcIsaPkg::opOr)  ? srcIsaPkg::aluOr  : srcIsaPkg::aluAdd;
    assign halted = (state == srcCtrlPkg::stHalted);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= srcCtrlPkg::stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        timerStart = 1'b0;
        {ctl.pcOut, ctl.zLowOut, ctl.mdrOut, ctl.regOut, ctl.cOut, ctl.inPortOut} = '0;
        {ctl.pcIn, ctl.irIn, ctl.yIn, ctl.zIn} = '0;
        {ctl.marIn, ctl.mdrIn, ctl.regIn, ctl.outPortIn} = '0;
        {ctl.gra, ctl.grb, ctl.grc, ctl.baOut} = '0;
        {ctl.incPc, ctl.memRead, ctl.memWrite, ctl.mdrRead} = '0;
        ctl.aluOp = srcIsaPkg::aluPassB;
        case (state)
            srcCtrlPkg::stIdle: begin
                if (run) begin
                    nextState = srcCtrlPkg::stT0;
                end
            end
            srcCtrlPkg::stHalted: ;         // held until reset
            srcCtrlPkg::stT0: begin
                ctl.pcOut = 1'b1;
                ctl.marIn = 1'b1;
                ctl.incPc = 1'b1;
                ctl.zIn = 1'b1;
                nextState = srcCtrlPkg::stT1;
            end
            srcCtrlPkg::stT1: begin
                ctl.zLowOut = 1'b1;
                ctl.pcIn = 1'b1;
                ctl.memRead = 1'b1;
                timerStart = 1'b1;
                nextState = srcCtrlPkg::stFetchWait;
            end
            srcCtrlPkg::stFetchWait: begin
                if (timerDone) begin
                    ctl.mdrIn = 1'b1;       // capture instruction word
                    ctl.mdrRead = 1'b1;
                    nextState = srcCtrlPkg::stT2;
                end
            end
            srcCtrlPkg::stT2: begin
                ctl.mdrOut = 1'b1;
                ctl.irIn = 1'b1;
                nextState = srcCtrlPkg::stT3;
            end
            srcCtrlPkg::stT3: begin
                nextState = srcCtrlPkg::stT0;
                if (isMem || isRegOp || opcode inside {srcIsaPkg::opLdi, srcIsaPkg::opAddi}) begin
                    ctl.grb = 1'b1;         // Y <= Rb, or 0 for ld/st/ldi with r0
                    ctl.baOut = !isRegOp && (opcode != srcIsaPkg::opAddi);
                    ctl.regOut = 1'b1;
                    ctl.yIn = 1'b1;
                    nextState = srcCtrlPkg::stT4;
                end else if (opcode == srcIsaPkg::opIn) begin
                    ctl.inPortOut = 1'b1;
                    ctl.gra = 1'b1;
                    ctl.regIn = 1'b1;
                end else if (opcode == srcIsaPkg::opOut) begin
                    ctl.gra = 1'b1;
                    ctl.regOut = 1'b1;
                    ctl.outPortIn = 1'b1;
                end else if (opcode == srcIsaPkg::opHalt) begin
                    nextState = srcCtrlPkg::stHalted;
                end
            end
            srcCtrlPkg::stT4: begin
                ctl.grc = isRegOp;
                ctl.regOut = isRegOp;
                ctl.cOut = !isRegOp;        // immediate forms
                ctl.aluOp = execAluOp;
                ctl.zIn = 1'b1;
                nextState = srcCtrlPkg::stT5;
            end
            srcCtrlPkg::stT5: begin
                ctl.zLowOut = 1'b1;
                ctl.marIn = isMem;          // effective address
                ctl.gra = !isMem;
                ctl.regIn = !isMem;
                nextState = isMem ? srcCtrlPkg::stT6 : srcCtrlPkg::stT0;
            end
            srcCtrlPkg::stT6: begin
                if (opcode == srcIsaPkg::opSt) begin
                    ctl.gra = 1'b1;         // MDR <= Ra
                    ctl.regOut = 1'b1;
                    ctl.mdrIn = 1'b1;
                    nextState = srcCtrlPkg::stT7;
                end else begin
                    ctl.memRead = 1'b1;
                    timerStart = 1'b1;
                    nextState = srcCtrlPkg::stMemWait;
                end
            end
            srcCtrlPkg::stMemWait: begin
                if (timerDone) begin
                    ctl.mdrIn = (opcode == srcIsaPkg::opLd);
                    ctl.mdrRead = (opcode == srcIsaPkg::opLd);
                    nextState = (opcode == srcIsaPkg::opLd) ? srcCtrlPkg::stT7 : srcCtrlPkg::stT0;
                end
            end
            srcCtrlPkg::stT7: begin
                if (opcode == srcIsaPkg::opSt) begin
                    ctl.memWrite = 1'b1;
                    timerStart = 1'b1;
                    nextState = srcCtrlPkg::stMemWait;
                end else begin
                    ctl.mdrOut = 1'b1;      // Ra <= loaded word
                    ctl.gra = 1'b1;
                    ctl.regIn = 1'b1;
                    nextState = srcCtrlPkg::stT0;
                end
            end
            default: nextState = srcCtrlPkg::stIdle;
        endcase
    end

    assert property (@(posedge clock) disable iff (reset) !(ctl.memRead && ctl.memWrite));
    assert property (@(posedge clock) disable iff (reset)
        $onehot0({ctl.pcOut, ctl.zLowOut, ctl.mdrOut, ctl.regOut, ctl.cOut, ctl.inPortOut}));

endmodule

//--- hdl/dataPath.sv
`timescale 1ns/10ps

module dataPath (
    input  logic clock,
    input  logic reset,
    controlBus.datapath ctl,
    memPort.master mem,
    input  logic [srcIsaPkg::wordWidth-1:0] inPortData,
    output logic [srcIsaPkg::wordWidth-1:0] outPortData
);

    logic [srcIsaPkg::wordWidth-1:0] bus;
    logic [srcIsaPkg::wordWidth-1:0] pc;
    logic [srcIsaPkg::wordWidth-1:0] ir;
    logic [srcIsaPkg::wordWidth-1:0] y;
    logic [srcIsaPkg::wordWidth-1:0] z;
    logic [srcIsaPkg::wordWidth-1:0] mar;
    logic [srcIsaPkg::wordWidth-1:0] mdr;
    logic [srcIsaPkg::wordWidth-1:0] inPort;
    logic [srcIsaPkg::wordWidth-1:0] regData;
    logic [srcIsaPkg::wordWidth-1:0] aluResult;
    srcIsaPkg::aluOpT aluOp;

    registerFile regFile (
        .clock (clock),
        .reset (reset),
        .ir    (ir),
        .gra   (ctl.gra),
        .grb   (ctl.grb),
        .grc   (ctl.grc),
        .baOut (ctl.baOut),
        .regIn (ctl.regIn),
        .busIn (bus),
        .busOut(regData)
    );

    assign aluOp = ctl.incPc ? srcIsaPkg::aluIncB : ctl.aluOp;     // PC+1 during fetch

    aluUnit alu (
        .aluOp (aluOp),
        .a     (y),
        .b     (bus),
        .result(aluResult)
    );

    // shared bus with one driver at most
    always_comb begin
        if (ctl.pcOut) begin
            bus = pc;
        end else if (ctl.zLowOut) begin
            bus = z;
        end else if (ctl.mdrOut) begin
            bus = mdr;
        end else if (ctl.regOut) begin
            bus = regData;
        end else if (ctl.cOut) begin
            bus = srcIsaPkg::signExtC(ir);
        end else if (ctl.inPortOut) begin
            bus = inPort;
        end else begin
            bus = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
            ir <= '0;
            outPortData <= '0;
        end else begin
            if (ctl.pcIn) pc <= bus;
            if (ctl.irIn) ir <= bus;
            if (ctl.outPortIn) outPortData <= bus;
        end
    end

    always_ff @(posedge clock) begin
        inPort <= inPortData;               // sampled every cycle
        if (ctl.yIn) y <= bus;
        if (ctl.zIn) z <= aluResult;
        if (ctl.marIn) mar <= bus;
        if (ctl.mdrIn) mdr <= ctl.mdrRead ? mem.readData : bus;
    end

    assign ctl.ir = ir;
    assign mem.address = mar[srcCtrlPkg::memAddrWidth-1:0];
    assign mem.writeData = mdr;
    assign mem.read = ctl.memRead;
    assign mem.write = ctl.memWrite;

    assert property (@(posedge clock) disable iff (reset)
        (mem.read || mem.write) |-> (mar < srcCtrlPkg::memDepth));

endmodule

//--- hdl/memPort.sv
`timescale 1ns/10ps

interface memPort;

    srcCtrlPkg::memAddrT address;
    logic [srcIsaPkg::wordWidth-1:0] writeData;
    logic [srcIsaPkg::wordWidth-1:0] readData;
    logic read;                         // single-cycle strobes
    logic write;

    modport master (output address, writeData, read, write, input readData);
    modport slave (input address, writeData, read, write, output readData);

endinterface

//--- hdl/miniSrc.sv
`timescale 1ns/10ps

module miniSrc #(
    parameter int memLatency = 2
) (
    input  logic clock,
    input  logic reset,
    input  logic run,
    input  logic [srcIsaPkg::wordWidth-1:0] inPortData,
    input  logic loadWrite,
    input  srcCtrlPkg::memAddrT loadAddress,
    input  logic [srcIsaPkg::wordWidth-1:0] loadData,
    output logic [srcIsaPkg::wordWidth-1:0] outPortData,
    output logic halted
);

    logic timerStart;
    logic timerDone;

    controlBus ctlBus ();
    memPort memBus ();

    controlSequencer seqUnit (
        .clock     (clock),
        .reset     (reset),
        .run       (run),
        .timerDone (timerDone),
        .timerStart(timerStart),
        .halted    (halted),
        .ctl       (ctlBus.sequencer)
    );

    waitTimer #(.memLatency(memLatency)) timerUnit (
        .clock(clock),
        .reset(reset),
        .start(timerStart),
        .done (timerDone)
    );

    dataPath pathUnit (
        .clock      (clock),
        .reset      (reset),
        .ctl        (ctlBus.datapath),
        .mem        (memBus.master),
        .inPortData (inPortData),
        .outPortData(outPortData)
    );

    wordMemory #(.memLatency(memLatency)) memUnit (
        .clock      (clock),
        .reset      (reset),
        .mem        (memBus.slave),
        .loadWrite  (loadWrite && !run),   // loading only while stopped
        .loadAddress(loadAddress),
        .loadData   (loadData)
    );

endmodule

//--- hdl/registerFile.sv
`timescale 1ns/10ps

module registerFile (
    input  logic clock,
    input  logic reset,
    input  logic [srcIsaPkg::wordWidth-1:0] ir,
    input  logic gra,
    input  logic grb,
    input  logic grc,
    input  logic baOut,
    input  logic regIn,
    input  logic [srcIsaPkg::wordWidth-1:0] busIn,
    output logic [srcIsaPkg::wordWidth-1:0] busOut
);

    localparam int aw = srcIsaPkg::regAddrWidth;

    logic [srcIsaPkg::wordWidth-1:0] regs [1 << aw];
    logic [aw-1:0] select;

    // field select, one of gra/grb/grc at a time
    assign select = ({aw{gra}} & ir[srcIsaPkg::raMsb -: aw])
                  | ({aw{grb}} & ir[srcIsaPkg::rbMsb -: aw])
                  | ({aw{grc}} & ir[srcIsaPkg::rcMsb -: aw]);

    assign busOut = (baOut && select == '0) ? '0 : regs[select];   // r0 as base reads 0

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < (1 << aw); i++) begin
                regs[i] <= '0;
            end
        end else if (regIn) begin
            regs[select] <= busIn;
        end
    end

endmodule

//--- hdl/srcCtrlPkg.sv
package srcCtrlPkg;

    localparam int memDepth = 512;
    localparam int memAddrWidth = $clog2(memDepth);

    typedef logic [memAddrWidth-1:0] memAddrT;

    localparam int stepCount = 12;

    // one-hot step encoding
    typedef enum logic [stepCount-1:0] {
        stIdle      = 12'b0000_0000_0001,
        stHalted    = 12'b0000_0000_0010,
        stT0        = 12'b0000_0000_0100,
        stT1        = 12'b0000_0000_1000,
        stFetchWait = 12'b0000_0001_0000,
        stT2        = 12'b0000_0010_0000,
        stT3        = 12'b0000_0100_0000,
        stT4        = 12'b0000_1000_0000,
        stT5        = 12'b0001_0000_0000,
        stT6        = 12'b0010_0000_0000,
        stMemWait   = 12'b0100_0000_0000,
        stT7        = 12'b1000_0000_0000
    } stepT;

endpackage

//--- hdl/srcIsaPkg.sv
package srcIsaPkg;

    localparam int wordWidth = 32;
    localparam int regAddrWidth = 4;
    localparam int opcodeWidth = 5;

    // msb of each instruction field
    localparam int opMsb = 31;
    localparam int raMsb = 26;
    localparam int rbMsb = 22;
    localparam int rcMsb = 18;
    localparam int constWidth = 19;         // C occupies bits 18..0

    typedef enum logic [opcodeWidth-1:0] {
        opLd   = 5'd0,
        opLdi  = 5'd1,
        opSt   = 5'd2,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opAddi = 5'd12,
        opIn   = 5'd22,
        opOut  = 5'd23,
        opNop  = 5'd26,
        opHalt = 5'd27
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluIncB,                            // PC increment
        aluPassB
    } aluOpT;

    // sign-extended C field of an instruction word
    function automatic logic [wordWidth-1:0] signExtC(input logic [wordWidth-1:0] instr);
        return {{(wordWidth - constWidth){instr[constWidth-1]}}, instr[constWidth-1:0]};
    endfunction

endpackage

//--- hdl/waitTimer.sv
`timescale 1ns/10ps

module waitTimer #(
    parameter int memLatency = 2
) (
    input  logic clock,
    input  logic reset,
    input  logic start,
    output logic done
);

    localparam int countWidth = $clog2(memLatency + 1);

    logic [countWidth-1:0] count;

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= countWidth'(memLatency);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign done = (count == countWidth'(1));    // one cycle at expiry

    // a new wait only once the previous one has expired
    assert property (@(posedge clock) disable iff (reset) start |-> (count <= countWidth'(1)));

endmodule

//--- hdl/wordMemory.sv
`timescale 1ns/10ps

module wordMemory #(
    parameter int memLatency = 2
) (
    input  logic clock,
    input  logic reset,
    memPort.slave mem,
    input  logic loadWrite,
    input  srcCtrlPkg::memAddrT loadAddress,
    input  logic [srcIsaPkg::wordWidth-1:0] loadData
);

    logic [srcIsaPkg::wordWidth-1:0] ram [srcCtrlPkg::memDepth];
    logic [srcIsaPkg::wordWidth-1:0] dataPipe [memLatency];
    logic [srcIsaPkg::wordWidth-1:0] heldData;
    logic [memLatency-1:0] validPipe;       // tracks read strobes down the line

    always_ff @(posedge clock) begin
        if (loadWrite) begin
            ram[loadAddress] <= loadData;
        end else if (mem.write) begin
            ram[mem.address] <= mem.writeData;
        end
        if (mem.read) dataPipe[0] <= ram[mem.address];
        for (int i = 1; i < memLatency; i++) begin
            dataPipe[i] <= dataPipe[i-1];
        end
        if (validPipe[memLatency-1]) heldData <= dataPipe[memLatency-1];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            validPipe <= '0;
        end else begin
            validPipe <= (validPipe << 1) | memLatency'(mem.read);
        end
    end

    // valid memLatency cycles after the strobe, held until the next read
    assign mem.readData = validPipe[memLatency-1] ? dataPipe[memLatency-1] : heldData;

endmodule

//--- miniSrc.f
hdl/srcIsaPkg.sv
hdl/srcCtrlPkg.sv
hdl/controlBus.sv
hdl/memPort.sv
hdl/waitTimer.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/controlSequencer.sv
hdl/dataPath.sv
hdl/wordMemory.sv
hdl/miniSrc.sv
sim/miniSrcTb.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
buildLog=build.log
simLog=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module miniSrcTb \
    -f miniSrc.f \
    -Mdir "$buildDir" -o miniSrcSim > "$buildLog" 2>&1
if [ $? -ne 0 ]; then
    cat "$buildLog"
    echo "build failed, see $buildLog"
    exit 1
fi

"./$buildDir/miniSrcSim" > "$simLog" 2>&1
simStatus=$?
cat "$simLog"
if [ $simStatus -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi

if grep -q "CHECKS FAILED" "$simLog"; then
    echo "testbench reported failures, see $simLog"
    exit 1
fi

echo "simulation finished without failures"
exit 0

//--- sim/miniSrcTb.sv
`timescale 1ns/10ps

module miniSrcTb;

    localparam int rowCount = 16;
    localparam int cyclesPerRow = 300;
    localparam int haltWaitLimit = 200;
    localparam int inSwitchDelay = 8;       // lands between the two in steps
    localparam int progLength = 6;

    typedef struct packed {
        srcIsaPkg::opcodeT op;
        logic [3:0] ra;
        logic [3:0] rb;
        logic [3:0] rc;
        logic [18:0] c;
    } rowT;

    logic clock;
    logic reset;
    logic run;
    logic [31:0] inPortData;
    logic loadWrite;
    srcCtrlPkg::memAddrT loadAddress;
    logic [31:0] loadData;
    logic [31:0] outPortData;
    logic halted;

    rowT testRows [rowCount];
    logic [31:0] modelMem [srcCtrlPkg::memDepth];     // words the testbench knows
    int seed = 32'h52e7_1d84;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    miniSrc #(.memLatency(2)) i_dut (
        .clock      (clock),
        .reset      (reset),
        .run        (run),
        .inPortData (inPortData),
        .loadWrite  (loadWrite),
        .loadAddress(loadAddress),
        .loadData   (loadData),
        .outPortData(outPortData),
        .halted     (halted)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= rowCount * cyclesPerRow) begin
            $display("timeout: run did not end within %0d cycles", rowCount * cyclesPerRow);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] encode(input srcIsaPkg::opcodeT op, input logic [3:0] ra,
                                           input logic [3:0] rb, input logic [18:0] low);
        return {op, ra, rb, low};
    endfunction

    function automatic logic [31:0] extendConst(input logic [18:0] c);
        return {{13{c[18]}}, c};
    endfunction

    // register contents after the two in steps
    function automatic logic [31:0] regValue(input logic [3:0] idx, input logic [31:0] in1,
                                             input logic [31:0] in2);
        return (idx == 4'd1) ? in1 : (idx == 4'd2) ? in2 : 32'h0;
    endfunction

    function automatic logic usesRc(input srcIsaPkg::opcodeT op);
        return op inside {srcIsaPkg::opAdd, srcIsaPkg::opSub, srcIsaPkg::opAnd, srcIsaPkg::opOr};
    endfunction

    task automatic setRow(input int idx, input srcIsaPkg::opcodeT op, input logic [3:0] ra,
                          input logic [3:0] rb, input logic [3:0] rc, input logic [18:0] c);
        testRows[idx].op = op;
        testRows[idx].ra = ra;
        testRows[idx].rb = rb;
        testRows[idx].rc = rc;
        testRows[idx].c = c;
    endtask

    task automatic buildRows();
        setRow(0, srcIsaPkg::opAdd, 4'd3, 4'd1, 4'd2, 19'h0);
        setRow(1, srcIsaPkg::opSub, 4'd3, 4'd1, 4'd2, 19'h0);
        setRow(2, srcIsaPkg::opAnd, 4'd3, 4'd1, 4'd2, 19'h0);
        setRow(3, srcIsaPkg::opOr, 4'd3, 4'd1, 4'd2, 19'h0);
        setRow(4, srcIsaPkg::opSub, 4'd3, 4'd2, 4'd1, 19'h0);
        setRow(5, srcIsaPkg::opAddi, 4'd3, 4'd1, 4'd0, 19'h00123);
        setRow(6, srcIsaPkg::opAddi, 4'd3, 4'd1, 4'd0, 19'h7fff0);     // -16
        setRow(7, srcIsaPkg::opAddi, 4'd3, 4'd1, 4'd0, 19'h40000);     // most negative C
        setRow(8, srcIsaPkg::opLdi, 4'd3, 4'd0, 4'd0, 19'h2abcd);
        setRow(9, srcIsaPkg::opLdi, 4'd3, 4'd0, 4'd0, 19'h7fffe);
        setRow(10, srcIsaPkg::opLdi, 4'd3, 4'd2, 4'd0, 19'h00010);
        setRow(11, srcIsaPkg::opSt, 4'd1, 4'd2, 4'd0, 19'h00010);
        setRow(12, srcIsaPkg::opSt, 4'd1, 4'd2, 4'd0, 19'h7fff8);
        setRow(13, srcIsaPkg::opSt, 4'd1, 4'd0, 4'd0, 19'h001f0);      // absolute address
        setRow(14, srcIsaPkg::opLd, 4'd3, 4'd0, 4'd0, 19'h00002);      // reads its own word
        setRow(15, srcIsaPkg::opLd, 4'd3, 4'd0, 4'd0, 19'h001f0);      // word stored by row 13
    endtask

    task automatic applyReset();
        @(negedge clock);
        reset = 1'b1;
        repeat (2) @(negedge clock);
        checkCount += 2;
        if (outPortData !== 32'h0) begin
            $display("Fail outPortData after reset: expected %h, got %h", 32'h0, outPortData);
            errorCount++;
        end
        if (halted !== 1'b0) begin
            $display("Fail halted after reset: expected %h, got %h", 1'b0, halted);
            errorCount++;
        end
        reset = 1'b0;
    endtask

    // in r1, in r2, test op, ld r3 after a store, out r3, halt
    task automatic loadProgram(input rowT row);
        logic [31:0] words [progLength];
        logic [18:0] low;
        low = usesRc(row.op) ? {row.rc, 15'h0} : row.c;
        words[0] = encode(srcIsaPkg::opIn, 4'd1, 4'd0, 19'h0);
        words[1] = encode(srcIsaPkg::opIn, 4'd2, 4'd0, 19'h0);
        words[2] = encode(row.op, row.ra, row.rb, low);
        words[3] = (row.op == srcIsaPkg::opSt) ? encode(srcIsaPkg::opLd, 4'd3, row.rb, row.c)
                                               : encode(srcIsaPkg::opNop, 4'd0, 4'd0, 19'h0);
        words[4] = encode(srcIsaPkg::opOut, 4'd3, 4'd0, 19'h0);
        words[5] = encode(srcIsaPkg::opHalt, 4'd0, 4'd0, 19'h0);
        for (int i = 0; i < progLength; i++) begin
            @(negedge clock);
            loadWrite = 1'b1;
            loadAddress = srcCtrlPkg::memAddrT'(i);
            loadData = words[i];
            modelMem[i] = words[i];
        end
        @(negedge clock);
        loadWrite = 1'b0;
    endtask

    task automatic computeExpected(input rowT row, input logic [31:0] in1,
                                   input logic [31:0] in2, output logic [31:0] expected);
        logic [31:0] base;
        logic [31:0] rcValue;
        logic [31:0] addr;
        base = regValue(row.rb, in1, in2);
        rcValue = regValue(row.rc, in1, in2);
        addr = base + extendConst(row.c);
        case (row.op)
            srcIsaPkg::opAdd: expected = base + rcValue;
            srcIsaPkg::opSub: expected = base - rcValue;
            srcIsaPkg::opAnd: expected = base & rcValue;
            srcIsaPkg::opOr: expected = base | rcValue;
            srcIsaPkg::opSt: begin
                modelMem[addr[srcCtrlPkg::memAddrWidth-1:0]] = regValue(row.ra, in1, in2);
                expected = modelMem[addr[srcCtrlPkg::memAddrWidth-1:0]];   // read back by ld r3
            end
            srcIsaPkg::opLd: expected = modelMem[addr[srcCtrlPkg::memAddrWidth-1:0]];
            default: expected = addr;       // addi and ldi
        endcase
    endtask

    initial begin
        logic [31:0] in1;
        logic [31:0] in2;
        logic [31:0] expected;
        int waited;
        reset = 1'b1;
        run = 1'b0;
        inPortData = 32'h0;
        loadWrite = 1'b0;
        loadAddress = '0;
        loadData = 32'h0;
        buildRows();
        for (int r = 0; r < rowCount; r++) begin
            in1 = $random(seed);
            in2 = $random(seed);
            if ((testRows[r].op inside {srcIsaPkg::opLd, srcIsaPkg::opSt}) &&
                    testRows[r].rb != 4'd0) begin
                in2 = 32'h100 | (in2 & 32'h7f);     // keep C(r2) clear of the program
            end
            applyReset();
            inPortData = in1;
            loadProgram(testRows[r]);
            computeExpected(testRows[r], in1, in2, expected);
            run = 1'b1;
            repeat (inSwitchDelay) @(negedge clock);
            inPortData = in2;                       // first in has completed by now
            waited = 0;
            while (!halted && waited < haltWaitLimit) begin
                @(negedge clock);
                waited++;
            end
            checkCount++;
            if (!halted) begin
                $display("row %0d: halted did not rise within %0d cycles", r, haltWaitLimit);
                errorCount++;
            end else begin
                checkCount += 2;
                if (outPortData !== expected) begin
                    $display("Fail outPortData row %0d: expected %h, got %h",
                             r, expected, outPortData);
                    errorCount++;
                end
                repeat (3) @(negedge clock);
                if (halted !== 1'b1) begin
                    $display("row %0d: halted dropped before the next reset", r);
                    errorCount++;
                end
            end
            run = 1'b0;
        end
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
